//--- hw/rob_consts.svh
`ifndef ROB_CONSTS_SVH
`define ROB_CONSTS_SVH

// buffer geometry
`define ROB_LEN    16   // entries
`define ROB_IDX_W  4    // tag bits, log2 of ROB_LEN
`define ROB_CNT_W  5    // occupancy bits, holds 0..ROB_LEN

// superscalar width, same for dispatch, cdb and retire
`define ROB_WAY    3

// datapath
`define REG_IDX_W  5    // architectural register index
`define XLEN       32   // result width

`endif

//--- hw/rob_pkg.sv
`default_nettype none

`include "rob_consts.svh"

package rob_pkg;

    typedef logic [`ROB_IDX_W-1:0] rob_tag_t;   // slot index into the buffer

    // one buffer entry as seen by retire
    typedef struct packed {
        logic                  busy;           // allocated, not yet retired
        logic                  done;           // result written by the cdb
        logic                  mem_op;         // load or store
        logic                  take_branch;    // resolved taken
        logic [`REG_IDX_W-1:0] reg_idx;        // dest reg, 0 if none
        logic [`XLEN-1:0]      value;
    } rob_entry_t;

    // decoder slot
    typedef struct packed {
        logic                  valid;
        logic                  dest_valid;     // has a destination register
        logic [`REG_IDX_W-1:0] dest_idx;
        logic                  mem_op;
    } dp_slot_t;

    // completion from the common data bus
    typedef struct packed {
        logic             valid;
        rob_tag_t         tag;
        logic [`XLEN-1:0] value;
        logic             take_branch;
    } cdb_slot_t;

    // rename update to the map table
    typedef struct packed {
        logic                  valid;
        logic [`REG_IDX_W-1:0] reg_idx;
        rob_tag_t              tag;
    } mt_slot_t;

    // commit report
    typedef struct packed {
        logic                  valid;
        rob_tag_t              tag;
        logic [`REG_IDX_W-1:0] reg_idx;
        logic [`XLEN-1:0]      value;
        logic                  take_branch;
    } rt_slot_t;

    // operand lookup from one reservation station slot
    typedef struct packed {
        rob_tag_t tag1;
        rob_tag_t tag2;
    } opnd_req_t;

    typedef struct packed {
        logic [`XLEN-1:0] value1;
        logic [`XLEN-1:0] value2;
        logic             ready1;       // tag1 entry has completed
        logic             ready2;
    } opnd_rsp_t;

    // entry write produced by dispatch
    typedef struct packed {
        logic                  we;
        logic [`REG_IDX_W-1:0] reg_idx;
        logic                  mem_op;
    } alloc_t;

endpackage

`default_nettype wire

//--- hw/rob_ptr.sv
`default_nettype none

`include "rob_consts.svh"

module rob_ptr (
    input  wire logic        clock,
    input  wire logic        rst_n,
    input  wire logic        squash,     // flush, wins over both counts
    input  wire logic [1:0]  dp_count,   // entries allocated this cycle
    input  wire logic [1:0]  rt_count,   // entries retired this cycle
    output rob_pkg::rob_tag_t head,      // oldest entry
    output rob_pkg::rob_tag_t tail,      // next free entry
    output logic [1:0]       free_num    // free entries, saturates at 3
);
    import rob_pkg::*;

    localparam logic [`ROB_CNT_W-1:0] DEPTH = `ROB_LEN;

    logic [`ROB_CNT_W-1:0] count_q;      // occupied entries
    logic [`ROB_CNT_W-1:0] count_d;
    logic [`ROB_CNT_W-1:0] free_cnt;
    rob_tag_t              head_d;
    rob_tag_t              tail_d;

    // pointers wrap for free, tag width is log2 of depth
    assign head_d = head + rob_tag_t'(rt_count);
    assign tail_d = tail + rob_tag_t'(dp_count);

    // separate counter so full and empty are told apart
    assign count_d = count_q
                   + {{(`ROB_CNT_W-2){1'b0}}, dp_count}
                   - {{(`ROB_CNT_W-2){1'b0}}, rt_count};

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            head    <= '0;
            tail    <= '0;
            count_q <= '0;
        end else if (squash) begin
            // whole buffer dropped
            head    <= '0;
            tail    <= '0;
            count_q <= '0;
        end else begin
            head    <= head_d;
            tail    <= tail_d;
            count_q <= count_d;
        end
    end

    assign free_cnt = DEPTH - count_q;

    // dispatch never needs more than one cycle's worth
    assign free_num = (free_cnt > 5'd3) ? 2'd3 : free_cnt[1:0];

endmodule

`default_nettype wire

//--- hw/rob_dispatch.sv
`default_nettype none

`include "rob_consts.svh"

module rob_dispatch (
    input  wire rob_pkg::dp_slot_t [`ROB_WAY-1:0] dp_in,
    input  wire rob_pkg::rob_tag_t                tail,      // tag of slot 0
    input  wire logic [1:0]                       free_num,
    output logic [1:0]                            dp_count,  // slots taken
    output rob_pkg::alloc_t [`ROB_WAY-1:0]        alloc,     // entry writes
    output rob_pkg::mt_slot_t [`ROB_WAY-1:0]      mt_out     // rename updates
);
    import rob_pkg::*;

    logic [`ROB_WAY-1:0] take;   // slot accepted this cycle

    // leading run of valid slots, cut off at free space
    always_comb begin
        logic run;
        run      = 1'b1;
        dp_count = 2'd0;
        for (int k = 0; k < `ROB_WAY; k++) begin
            run      = run & dp_in[k].valid & (2'(k) < free_num);
            take[k]  = run;
            dp_count = dp_count + {1'b0, run};
        end
    end

    always_comb begin
        rob_tag_t slot_tag;
        for (int k = 0; k < `ROB_WAY; k++) begin
            slot_tag = tail + rob_tag_t'(k);   // wraps at ROB_LEN

            alloc[k].we      = take[k];
            // no destination means reg 0 in the entry
            alloc[k].reg_idx = (take[k] && dp_in[k].dest_valid) ? dp_in[k].dest_idx : '0;
            alloc[k].mem_op  = take[k] & dp_in[k].mem_op;

            // map table only renames real destinations
            mt_out[k].valid   = take[k] & dp_in[k].dest_valid;
            mt_out[k].reg_idx = mt_out[k].valid ? dp_in[k].dest_idx : '0;
            mt_out[k].tag     = mt_out[k].valid ? slot_tag : '0;
        end
    end

endmodule

`default_nettype wire

//--- hw/rob_table.sv
`default_nettype none

`include "rob_consts.svh"

module rob_table (
    input  wire logic                              clock,
    input  wire logic                              rst_n,
    input  wire logic                              squash,
    input  wire rob_pkg::alloc_t   [`ROB_WAY-1:0]  alloc,     // from dispatch
    input  wire rob_pkg::rob_tag_t                 tail,
    input  wire rob_pkg::cdb_slot_t [`ROB_WAY-1:0] cdb_in,    // completions
    input  wire rob_pkg::rob_tag_t                 head,
    input  wire logic [1:0]                        rt_count,  // entries leaving
    input  wire rob_pkg::opnd_req_t [`ROB_WAY-1:0] opnd_req,
    output rob_pkg::rob_entry_t [`ROB_WAY-1:0]     window,    // head..head+2
    output rob_pkg::opnd_rsp_t  [`ROB_WAY-1:0]     opnd_rsp
);
    import rob_pkg::*;

    // per-entry flags
    logic [`ROB_LEN-1:0] busy_q;
    logic [`ROB_LEN-1:0] done_q;

    // per-entry payload
    logic [`ROB_LEN-1:0]                 mem_q;
    logic [`ROB_LEN-1:0]                 brn_q;
    logic [`ROB_LEN-1:0][`REG_IDX_W-1:0] reg_q;
    logic [`ROB_LEN-1:0][`XLEN-1:0]      val_q;

    rob_tag_t [`ROB_WAY-1:0] wr_idx;    // tail+k
    rob_tag_t [`ROB_WAY-1:0] win_idx;   // head+k

    always_comb begin
        for (int k = 0; k < `ROB_WAY; k++) begin
            wr_idx[k]  = tail + rob_tag_t'(k);
            win_idx[k] = head + rob_tag_t'(k);
        end
    end

    // later loops win on a shared index: alloc, then retire, then cdb
    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            busy_q <= '0;
            done_q <= '0;
        end else if (squash) begin
            busy_q <= '0;   // drops any dispatch or cdb this cycle
            done_q <= '0;
        end else begin
            for (int k = 0; k < `ROB_WAY; k++) begin
                if (alloc[k].we) begin
                    busy_q[wr_idx[k]] <= 1'b1;
                    done_q[wr_idx[k]] <= 1'b0;
                end
            end
            for (int k = 0; k < `ROB_WAY; k++) begin
                if (2'(k) < rt_count) begin
                    busy_q[win_idx[k]] <= 1'b0;
                    done_q[win_idx[k]] <= 1'b0;
                end
            end
            for (int k = 0; k < `ROB_WAY; k++) begin
                if (cdb_in[k].valid)
                    done_q[cdb_in[k].tag] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (!squash) begin
            for (int k = 0; k < `ROB_WAY; k++) begin
                if (alloc[k].we) begin
                    mem_q[wr_idx[k]] <= alloc[k].mem_op;
                    reg_q[wr_idx[k]] <= alloc[k].reg_idx;
                    brn_q[wr_idx[k]] <= 1'b0;   // not taken until resolved
                end
            end
            for (int k = 0; k < `ROB_WAY; k++) begin
                if (cdb_in[k].valid) begin
                    val_q[cdb_in[k].tag] <= cdb_in[k].value;
                    brn_q[cdb_in[k].tag] <= cdb_in[k].take_branch;
                end
            end
        end
    end

    // retire window, zero latency
    always_comb begin
        for (int k = 0; k < `ROB_WAY; k++) begin
            window[k].busy        = busy_q[win_idx[k]];
            window[k].done        = done_q[win_idx[k]];
            window[k].mem_op      = mem_q[win_idx[k]];
            window[k].take_branch = brn_q[win_idx[k]];
            window[k].reg_idx     = reg_q[win_idx[k]];
            window[k].value       = val_q[win_idx[k]];
        end
    end

    // operand lookup, ready once completed
    always_comb begin
        for (int k = 0; k < `ROB_WAY; k++) begin
            opnd_rsp[k].value1 = val_q[opnd_req[k].tag1];
            opnd_rsp[k].value2 = val_q[opnd_req[k].tag2];
            opnd_rsp[k].ready1 = done_q[opnd_req[k].tag1];
            opnd_rsp[k].ready2 = done_q[opnd_req[k].tag2];
        end
    end

endmodule

`default_nettype wire

//--- hw/rob_retire.sv
`default_nettype none

`include "rob_consts.svh"

module rob_retire (
    input  wire rob_pkg::rob_entry_t [`ROB_WAY-1:0] window,   // head..head+2
    input  wire rob_pkg::rob_tag_t                  head,
    input  wire logic                               mem_busy, // memory stage stall
    output rob_pkg::rt_slot_t [`ROB_WAY-1:0]        rt_out,
    output logic [1:0]                              rt_count
);
    import rob_pkg::*;

    logic [`ROB_WAY-1:0] ok;   // slot retires this cycle

    always_comb begin
        logic prev;       // all older slots retire
        logic mem_seen;   // an older slot in the window is a memory op
        logic risky;      // memory op or taken branch
        prev     = 1'b1;
        mem_seen = 1'b0;
        for (int k = 0; k < `ROB_WAY; k++) begin
            risky    = window[k].mem_op | window[k].take_branch;
            ok[k]    = prev
                     & window[k].busy & window[k].done
                     & ~(risky & (mem_busy | mem_seen));
            mem_seen = mem_seen | window[k].mem_op;
            prev     = ok[k];   // strictly in order
        end
    end

    always_comb begin
        rt_count = 2'd0;
        for (int k = 0; k < `ROB_WAY; k++) begin
            rt_count = rt_count + {1'b0, ok[k]};
            if (ok[k]) begin
                rt_out[k].valid       = 1'b1;
                rt_out[k].tag         = head + rob_tag_t'(k);
                rt_out[k].reg_idx     = window[k].reg_idx;
                rt_out[k].value       = window[k].value;
                rt_out[k].take_branch = window[k].take_branch;
            end else begin
                rt_out[k] = '0;   // idle slot reads as all zero
            end
        end
    end

endmodule

`default_nettype wire

//--- hw/rob_top.sv
`default_nettype none

`include "rob_consts.svh"

module rob_top (
    input  wire logic                              clock,
    input  wire logic                              rst_n,
    input  wire logic                              squash,    // one-cycle flush
    input  wire logic                              mem_busy,
    input  wire rob_pkg::dp_slot_t  [`ROB_WAY-1:0] dp_in,
    input  wire rob_pkg::cdb_slot_t [`ROB_WAY-1:0] cdb_in,
    input  wire rob_pkg::opnd_req_t [`ROB_WAY-1:0] opnd_req,
    output rob_pkg::mt_slot_t  [`ROB_WAY-1:0]      mt_out,
    output rob_pkg::rt_slot_t  [`ROB_WAY-1:0]      rt_out,
    output rob_pkg::opnd_rsp_t [`ROB_WAY-1:0]      opnd_rsp,
    output logic [1:0]                             free_num
);
    import rob_pkg::*;

    rob_tag_t                  head;
    rob_tag_t                  tail;
    logic [1:0]                dp_count;   // dispatch -> pointers
    logic [1:0]                rt_count;   // retire -> pointers and table
    alloc_t [`ROB_WAY-1:0]     alloc;
    rob_entry_t [`ROB_WAY-1:0] window;

    rob_ptr u_ptr (
        .clock    (clock),
        .rst_n    (rst_n),
        .squash   (squash),
        .dp_count (dp_count),
        .rt_count (rt_count),
        .head     (head),
        .tail     (tail),
        .free_num (free_num)
    );

    rob_dispatch u_dispatch (
        .dp_in    (dp_in),
        .tail     (tail),
        .free_num (free_num),
        .dp_count (dp_count),
        .alloc    (alloc),
        .mt_out   (mt_out)
    );

    rob_table u_table (
        .clock    (clock),
        .rst_n    (rst_n),
        .squash   (squash),
        .alloc    (alloc),
        .tail     (tail),
        .cdb_in   (cdb_in),
        .head     (head),
        .rt_count (rt_count),
        .opnd_req (opnd_req),
        .window   (window),
        .opnd_rsp (opnd_rsp)
    );

    rob_retire u_retire (
        .window   (window),
        .head     (head),
        .mem_busy (mem_busy),
        .rt_out   (rt_out),
        .rt_count (rt_count)
    );

endmodule

`default_nettype wire

//--- verification/rob_checker.sv
`default_nettype none

`include "rob_consts.svh"

module rob_checker (
    input  wire logic                              clock,
    input  wire logic                              check_en,   // low until out of reset
    input  wire rob_pkg::mt_slot_t  [`ROB_WAY-1:0] mt_out,
    input  wire rob_pkg::rt_slot_t  [`ROB_WAY-1:0] rt_out,
    input  wire rob_pkg::opnd_rsp_t [`ROB_WAY-1:0] opnd_rsp,
    input  wire logic [1:0]                        free_num,
    input  wire rob_pkg::mt_slot_t  [`ROB_WAY-1:0] exp_mt,     // from the model
    input  wire rob_pkg::rt_slot_t  [`ROB_WAY-1:0] exp_rt,
    input  wire rob_pkg::opnd_rsp_t [`ROB_WAY-1:0] exp_opnd,
    input  wire logic [1:0]                        exp_free,
    output int                                     err_count,
    output int                                     check_count
);
    import rob_pkg::*;

    initial begin
        err_count   = 0;
        check_count = 0;
    end

    task automatic report(input string msg);
        err_count = err_count + 1;
        $display("FAILED %0t: %s", $time, msg);
    endtask

    // outputs are combinational, settled well before the falling edge
    always @(negedge clock) begin
        if (check_en) begin
            check_count = check_count + 1;
            if (free_num !== exp_free)
                report($sformatf("free_num is %0d, expected %0d", free_num, exp_free));
            for (int k = 0; k < `ROB_WAY; k++) begin
                if (mt_out[k] !== exp_mt[k])
                    report($sformatf("mt_out[%0d] is %h, expected %h", k, mt_out[k], exp_mt[k]));
                if (rt_out[k] !== exp_rt[k])
                    report($sformatf("rt_out[%0d] is %h, expected %h", k, rt_out[k], exp_rt[k]));
                if (opnd_rsp[k].ready1 !== exp_opnd[k].ready1 ||
                    opnd_rsp[k].ready2 !== exp_opnd[k].ready2)
                    report($sformatf("opnd_rsp[%0d] ready is %b%b, expected %b%b", k,
                                     opnd_rsp[k].ready1, opnd_rsp[k].ready2,
                                     exp_opnd[k].ready1, exp_opnd[k].ready2));
                // value only defined once the entry has completed
                if (exp_opnd[k].ready1 && opnd_rsp[k].value1 !== exp_opnd[k].value1)
                    report($sformatf("opnd_rsp[%0d].value1 is %h, expected %h", k,
                                     opnd_rsp[k].value1, exp_opnd[k].value1));
                if (exp_opnd[k].ready2 && opnd_rsp[k].value2 !== exp_opnd[k].value2)
                    report($sformatf("opnd_rsp[%0d].value2 is %h, expected %h", k,
                                     opnd_rsp[k].value2, exp_opnd[k].value2));
            end
        end
    end

endmodule

`default_nettype wire

//--- verification/rob_tb.sv
`default_nettype none

`include "rob_consts.svh"

module rob_tb;
    import rob_pkg::*;

    localparam int PHASES    = 4;
    localparam int PHASE_LEN = 500;
    localparam int TIMEOUT   = PHASES * PHASE_LEN + 200;   // reset plus slack
    // traffic mix of the mixed, stall, full and squash phases
    localparam int PCT_DP [PHASES]    = '{60, 60, 95, 70};
    localparam int PCT_MEM [PHASES]   = '{20, 50, 20, 25};
    localparam int PCT_STALL [PHASES] = '{15, 60, 10, 20};
    localparam int PCT_CDB [PHASES]   = '{70, 70, 15, 70};
    localparam int SQUASH_PM [PHASES] = '{5, 5, 2, 40};     // per mille

    logic       clock;
    logic       rst_n;
    logic       squash;
    logic       mem_busy;
    logic [1:0] free_num;
    logic [1:0] exp_free;
    logic       check_en;
    dp_slot_t  [`ROB_WAY-1:0] dp_in;
    cdb_slot_t [`ROB_WAY-1:0] cdb_in;
    opnd_req_t [`ROB_WAY-1:0] opnd_req;
    mt_slot_t  [`ROB_WAY-1:0] mt_out, exp_mt;
    rt_slot_t  [`ROB_WAY-1:0] rt_out, exp_rt;
    opnd_rsp_t [`ROB_WAY-1:0] opnd_rsp, exp_opnd;
    int err_count;
    int check_count;
    int cycle_cnt = 0;
    int phase;

    // reference model with one row per entry
    logic                  m_busy [`ROB_LEN];
    logic                  m_done [`ROB_LEN];
    logic                  m_mem [`ROB_LEN];
    logic                  m_brn [`ROB_LEN];   // resolved taken
    logic [`REG_IDX_W-1:0] m_reg [`ROB_LEN];
    logic [`XLEN-1:0]      m_val [`ROB_LEN];
    int m_head;
    int m_tail;
    int m_count;
    int exp_dp_cnt;   // slots the DUT should take this cycle
    int exp_rt_cnt;

    rob_top u_dut (.*);
    rob_checker rob_checker (.*);

    always #20 clock = ~clock;

    always @(posedge clock) begin
        cycle_cnt = cycle_cnt + 1;
        if (cycle_cnt > TIMEOUT) begin
            $display("timeout: run still going after %0d cycles", TIMEOUT);
            $display("FAIL: see errors above");
            $finish;
        end
    end

    function automatic logic chance(input int pct);
        return int'($urandom_range(0, 99)) < pct;
    endfunction

    function automatic string phase_name(input int p);
        case (p)
            0:       return "mixed traffic";
            1:       return "memory stalls";
            2:       return "full buffer";
            default: return "frequent squash";
        endcase
    endfunction

    task automatic clear_model();
        for (int i = 0; i < `ROB_LEN; i++) begin
            m_busy[i] = 1'b0;
            m_done[i] = 1'b0;
        end
        m_head  = 0;
        m_tail  = 0;
        m_count = 0;
    endtask

    // effect of the edge that just passed in buffer update order
    task automatic apply_cycle();
        int idx;
        if (squash) begin
            clear_model();
        end else begin
            for (int k = 0; k < exp_dp_cnt; k++) begin
                idx         = (m_tail + k) % `ROB_LEN;
                m_busy[idx] = 1'b1;
                m_done[idx] = 1'b0;
                m_mem[idx]  = dp_in[k].mem_op;
                m_brn[idx]  = 1'b0;
                m_reg[idx]  = dp_in[k].dest_valid ? dp_in[k].dest_idx : '0;
            end
            for (int k = 0; k < exp_rt_cnt; k++) begin
                idx         = (m_head + k) % `ROB_LEN;
                m_busy[idx] = 1'b0;
                m_done[idx] = 1'b0;
            end
            for (int k = 0; k < `ROB_WAY; k++) begin
                if (cdb_in[k].valid) begin
                    m_done[cdb_in[k].tag] = 1'b1;
                    m_val[cdb_in[k].tag]  = cdb_in[k].value;
                    m_brn[cdb_in[k].tag]  = cdb_in[k].take_branch;
                end
            end
            m_head  = (m_head + exp_rt_cnt) % `ROB_LEN;
            m_tail  = (m_tail + exp_dp_cnt) % `ROB_LEN;
            m_count = m_count + exp_dp_cnt - exp_rt_cnt;
        end
    endtask

    task automatic draw_inputs();
        int          cand[$];   // busy and not yet completed
        int          pick;
        int          n;
        logic [31:0] r;
        squash   = $urandom_range(0, 999) < SQUASH_PM[phase];
        mem_busy = chance(PCT_STALL[phase]);
        for (int k = 0; k < `ROB_WAY; k++) begin
            r                   = $urandom;
            dp_in[k].valid      = chance(PCT_DP[phase]);
            dp_in[k].dest_valid = chance(80);
            dp_in[k].dest_idx   = r[`REG_IDX_W-1:0];
            dp_in[k].mem_op     = chance(PCT_MEM[phase]);
            opnd_req[k].tag1    = r[8+`ROB_IDX_W-1:8];
            opnd_req[k].tag2    = r[16+`ROB_IDX_W-1:16];
        end
        for (int i = 0; i < `ROB_LEN; i++)
            if (m_busy[i] && !m_done[i])
                cand.push_back(i);
        cdb_in = '0;
        n = chance(PCT_CDB[phase]) ? int'($urandom_range(1, `ROB_WAY)) : 0;
        for (int k = 0; k < n && cand.size() > 0; k++) begin
            pick                  = int'($urandom_range(0, cand.size() - 1));
            cdb_in[k].valid       = 1'b1;
            cdb_in[k].tag         = rob_tag_t'(cand[pick]);
            cdb_in[k].value       = $urandom;
            cdb_in[k].take_branch = chance(20);
            cand.delete(pick);   // tags stay distinct
        end
    endtask

    task automatic compute_expected();
        int   free_left;
        int   idx;
        logic run;
        logic prev;
        logic mem_seen;   // older memory op in the window
        logic ok;
        free_left  = (`ROB_LEN - m_count > 3) ? 3 : `ROB_LEN - m_count;
        exp_free   = 2'(free_left);
        run        = 1'b1;
        exp_dp_cnt = 0;
        for (int k = 0; k < `ROB_WAY; k++) begin
            run       = run && dp_in[k].valid && (k < free_left);
            exp_mt[k] = '0;
            if (run) begin
                exp_dp_cnt = exp_dp_cnt + 1;
                if (dp_in[k].dest_valid) begin
                    exp_mt[k].valid   = 1'b1;
                    exp_mt[k].reg_idx = dp_in[k].dest_idx;
                    exp_mt[k].tag     = rob_tag_t'((m_tail + k) % `ROB_LEN);
                end
            end
        end
        prev       = 1'b1;
        mem_seen   = 1'b0;
        exp_rt_cnt = 0;
        for (int k = 0; k < `ROB_WAY; k++) begin
            idx       = (m_head + k) % `ROB_LEN;
            ok        = prev && m_busy[idx] && m_done[idx] &&
                        !((m_mem[idx] || m_brn[idx]) && (mem_busy || mem_seen));
            exp_rt[k] = '0;
            if (ok) begin
                exp_rt_cnt                = exp_rt_cnt + 1;
                exp_rt[k].valid           = 1'b1;
                exp_rt[k].tag             = rob_tag_t'(idx);
                exp_rt[k].reg_idx         = m_reg[idx];
                exp_rt[k].value           = m_val[idx];
                exp_rt[k].take_branch     = m_brn[idx];
            end
            mem_seen = mem_seen || (m_busy[idx] && m_mem[idx]);
            prev     = ok;
        end
        for (int k = 0; k < `ROB_WAY; k++) begin
            exp_opnd[k].ready1 = m_done[opnd_req[k].tag1];
            exp_opnd[k].ready2 = m_done[opnd_req[k].tag2];
            exp_opnd[k].value1 = m_val[opnd_req[k].tag1];
            exp_opnd[k].value2 = m_val[opnd_req[k].tag2];
        end
    endtask

    initial begin
        int errs_before;
        int failed_tests;
        void'($urandom(32'h29eda8f2));
        clock        = 1'b0;
        rst_n        = 1'b0;
        squash       = 1'b0;
        mem_busy     = 1'b0;
        dp_in        = '0;
        cdb_in       = '0;
        opnd_req     = '0;
        exp_mt       = '0;
        exp_rt       = '0;
        exp_opnd     = '0;
        exp_free     = 2'd3;
        check_en     = 1'b0;
        exp_dp_cnt   = 0;
        exp_rt_cnt   = 0;
        failed_tests = 0;
        phase        = 0;
        for (int i = 0; i < `ROB_LEN; i++) begin
            m_mem[i] = 1'b0;
            m_brn[i] = 1'b0;
            m_reg[i] = '0;
            m_val[i] = '0;
        end
        clear_model();
        repeat (2) @(posedge clock);
        #2 rst_n = 1'b1;
        check_en = 1'b1;   // idle inputs, first compare sees the empty buffer
        for (int p = 0; p < PHASES; p++) begin
            phase       = p;
            errs_before = err_count;
            repeat (PHASE_LEN) begin
                @(posedge clock);
                #2;
                apply_cycle();
                draw_inputs();
                compute_expected();
            end
            @(negedge clock);   // last compare of the phase
            #1;
            if (err_count == errs_before) begin
                $display("test %0d %s: passed", p, phase_name(p));
            end else begin
                failed_tests = failed_tests + 1;
                $display("test %0d %s: failed, %0d errors", p, phase_name(p),
                         err_count - errs_before);
            end
        end
        $display("summary: %0d tests, %0d passed, %0d failed, %0d checks, %0d errors",
                 PHASES, PHASES - failed_tests, failed_tests, check_count, err_count);
        if (err_count == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- compile.f
+incdir+hw
hw/rob_pkg.sv
hw/rob_ptr.sv
hw/rob_dispatch.sv
hw/rob_table.sv
hw/rob_retire.sv
hw/rob_top.sv
verification/rob_checker.sv
verification/rob_tb.sv

//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing -Wno-fatal -j 0
TOP       = rob_tb
FILELIST  = compile.f
OBJ_DIR   = obj_dir
PASS_MSG  = PASS: all tests

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
